// File: design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ==========================================================
// Datapath widths and reset vector
// ==========================================================
`define RV_XLEN       32
`define RV_REG_ADDR_W 5
`define RV_RESET_PC   32'h0000_0000

// ==========================================================
// RV32I major opcodes
// ==========================================================
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

// funct3 of register and immediate ALU operations
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// Only word accesses are kept
`define RV_F3_WORD 3'b010

// Branch conditions
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

// File: design/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // ==========================================================
  // Vector types
  // ==========================================================
  typedef logic [`RV_XLEN-1:0]       word_t;
  typedef logic [`RV_XLEN-1:0]       addr_t;
  typedef logic [31:0]               instr_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;

  // Branch funct3 carried unchanged into execute
  typedef logic [2:0] br_cond_t;

  // ==========================================================
  // Operation enums
  // ==========================================================

  // PASS_B forwards operand b for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // How execute retires an instruction
  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_ALU,
    KIND_LOAD,
    KIND_STORE,
    KIND_BRANCH,
    KIND_JUMP
  } instr_kind_t;

endpackage

// File: design/rv_stage_if.sv
`timescale 1ns/1ns

// Fetch buffer to decode
interface rv_fetch_if import rv_pkg::*; ();

  logic   valid;
  logic   ready;
  addr_t  pc;
  instr_t instr;

  modport producer (output valid, output pc, output instr, input ready);
  modport consumer (input valid, input pc, input instr, output ready);

endinterface

// Decode issue register to execute
interface rv_issue_if import rv_pkg::*; ();

  logic        valid;
  logic        ready;
  addr_t       pc;
  instr_kind_t kind;
  alu_op_t     alu_op;
  word_t       op_a;
  word_t       op_b;
  word_t       store_data;
  word_t       imm;
  br_cond_t    cond;
  // Zero when the instruction writes no register
  reg_idx_t    rd;

  modport producer (
    output valid, output pc, output kind, output alu_op, output op_a, output op_b,
    output store_data, output imm, output cond, output rd,
    input  ready
  );

  modport consumer (
    input  valid, input pc, input kind, input alu_op, input op_a, input op_b,
    input  store_data, input imm, input cond, input rd,
    output ready
  );

endinterface

// File: design/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_fetch import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // Taken branch or JAL from execute
  input  logic   redirect_i,
  input  addr_t  redirect_pc_i,
  // Instruction memory
  output logic   imem_valid_o,
  output addr_t  imem_addr_o,
  input  logic   imem_ready_i,
  input  instr_t imem_rdata_i,
  rv_fetch_if.producer fetch
);

  logic  run_q;
  addr_t pc_q;
  logic  imem_done;
  logic  buf_pop;

  // ==========================================================
  // Request side
  // ==========================================================

  // Ask while the buffer is empty or drains this cycle
  assign imem_valid_o = run_q && (!fetch.valid || fetch.ready) && !redirect_i;
  assign imem_addr_o  = pc_q;
  assign imem_done    = imem_valid_o && imem_ready_i;
  assign buf_pop      = fetch.valid && fetch.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q       <= 1'b0;
      pc_q        <= `RV_RESET_PC;
      fetch.valid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (redirect_i) begin
        // Wrong-path entry is dropped
        pc_q        <= redirect_pc_i;
        fetch.valid <= 1'b0;
      end else if (imem_done) begin
        pc_q        <= pc_q + addr_t'(4);
        fetch.valid <= 1'b1;
      end else if (buf_pop) begin
        fetch.valid <= 1'b0;
      end
    end
  end

  // ==========================================================
  // One-entry fetch buffer
  // ==========================================================
  always_ff @(posedge clk) begin
    if (imem_done) begin
      fetch.pc    <= pc_q;
      fetch.instr <= imem_rdata_i;
    end
  end

  // Pending request keeps its address until the memory takes it
  a_imem_addr_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    imem_valid_o && !imem_ready_i |=> $stable(imem_addr_o)
  );

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Read ports
  input  reg_idx_t rd_idx_a_i,
  input  reg_idx_t rd_idx_b_i,
  output word_t    rd_data_a_o,
  output word_t    rd_data_b_o,
  // Write port from execute
  input  logic     wr_en_i,
  input  reg_idx_t wr_idx_i,
  input  word_t    wr_data_i
);

  localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

  // x0 has no storage
  word_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Reads see the old value during a same-cycle write
  assign rd_data_a_o = (rd_idx_a_i == '0) ? '0 : regs_q[rd_idx_a_i];
  assign rd_data_b_o = (rd_idx_b_i == '0) ? '0 : regs_q[rd_idx_b_i];

  a_wr_idx_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en_i |-> !$isunknown(wr_idx_i)
  );

endmodule

// File: design/rv_decode.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_decode import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  rv_fetch_if.consumer fetch,
  rv_issue_if.producer issue,
  input  logic     redirect_i,
  // Destination held in execute
  input  logic     busy_i,
  input  reg_idx_t busy_rd_i,
  // Write-back from execute into the register file
  input  logic     wr_en_i,
  input  reg_idx_t wr_idx_i,
  input  word_t    wr_data_i
);

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      rs1_data;
  word_t      rs2_data;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  instr_kind_t dec_kind;
  alu_op_t     dec_alu_op;
  word_t       dec_imm;
  logic        dec_use_imm;
  logic        dec_writes;
  logic        hazard;
  logic        take;

  assign instr  = fetch.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // ==========================================================
  // Immediate formats
  // ==========================================================
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // alt picks SUB or SRA
  function automatic alu_op_t alu_from_f3(logic [2:0] f3, logic alt);
    alu_op_t op;
    case (f3)
      `RV_F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      `RV_F3_SLL:  op = ALU_SLL;
      `RV_F3_SLT:  op = ALU_SLT;
      `RV_F3_SLTU: op = ALU_SLTU;
      `RV_F3_XOR:  op = ALU_XOR;
      `RV_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:   op = ALU_OR;
      `RV_F3_AND:  op = ALU_AND;
      default:     op = ALU_ADD;
    endcase
    return op;
  endfunction

  // ==========================================================
  // Opcode decode
  // ==========================================================
  always_comb begin
    dec_kind    = KIND_NONE;
    dec_alu_op  = ALU_ADD;
    dec_imm     = imm_i;
    dec_use_imm = 1'b0;
    dec_writes  = 1'b0;
    case (opcode)
      `RV_OP_IMM: begin
        dec_kind    = KIND_ALU;
        dec_alu_op  = alu_from_f3(funct3, instr[30] && (funct3 == `RV_F3_SR));
        dec_use_imm = 1'b1;
        dec_writes  = 1'b1;
      end
      `RV_OP_REG: begin
        dec_kind   = KIND_ALU;
        dec_alu_op = alu_from_f3(funct3, instr[30]);
        dec_writes = 1'b1;
      end
      `RV_OP_LUI: begin
        dec_kind    = KIND_ALU;
        dec_alu_op  = ALU_PASS_B;
        dec_imm     = imm_u;
        dec_use_imm = 1'b1;
        dec_writes  = 1'b1;
      end
      `RV_OP_LOAD: begin
        if (funct3 == `RV_F3_WORD) begin
          dec_kind    = KIND_LOAD;
          dec_use_imm = 1'b1;
          dec_writes  = 1'b1;
        end
      end
      `RV_OP_STORE: begin
        if (funct3 == `RV_F3_WORD) begin
          dec_kind    = KIND_STORE;
          dec_imm     = imm_s;
          dec_use_imm = 1'b1;
        end
      end
      `RV_OP_BRANCH: begin
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          dec_kind = KIND_BRANCH;
          dec_imm  = imm_b;
        end
      end
      `RV_OP_JAL: begin
        dec_kind   = KIND_JUMP;
        dec_imm    = imm_j;
        dec_writes = 1'b1;
      end
      default: ;
    endcase
  end

  rv_regfile i_rv_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_idx_a_i  (rs1),
    .rd_idx_b_i  (rs2),
    .rd_data_a_o (rs1_data),
    .rd_data_b_o (rs2_data),
    .wr_en_i     (wr_en_i),
    .wr_idx_i    (wr_idx_i),
    .wr_data_i   (wr_data_i)
  );

  // ==========================================================
  // Hazard hold and issue register
  // ==========================================================
  function automatic logic reads_reg(reg_idx_t dst, reg_idx_t a, reg_idx_t b);
    return (dst != '0) && ((dst == a) || (dst == b));
  endfunction

  // The issue register's writer reaches execute before it can write back
  assign hazard = (busy_i && reads_reg(busy_rd_i, rs1, rs2)) ||
                  (issue.valid && reads_reg(issue.rd, rs1, rs2));

  assign fetch.ready = (!issue.valid || issue.ready) && !hazard;
  assign take        = fetch.valid && fetch.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue.valid <= 1'b0;
    end else if (redirect_i) begin
      issue.valid <= 1'b0;
    end else if (take) begin
      issue.valid <= 1'b1;
    end else if (issue.ready) begin
      issue.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      issue.pc         <= fetch.pc;
      issue.kind       <= dec_kind;
      issue.alu_op     <= dec_alu_op;
      issue.op_a       <= rs1_data;
      issue.op_b       <= dec_use_imm ? dec_imm : rs2_data;
      issue.store_data <= rs2_data;
      issue.imm        <= dec_imm;
      issue.cond       <= funct3;
      issue.rd         <= dec_writes ? rd : '0;
    end
  end

  // Only execute or a redirect removes a presented instruction
  a_issue_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue.valid && !issue.ready && !redirect_i |=> issue.valid
  );

endmodule

// File: design/rv_execute.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_execute import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  rv_issue_if.consumer issue,
  output logic     redirect_o,
  output addr_t    redirect_pc_o,
  output logic     busy_o,
  output reg_idx_t busy_rd_o,
  // Register write-back
  output logic     wr_en_o,
  output reg_idx_t wr_idx_o,
  output word_t    wr_data_o,
  // Data memory
  output logic     dmem_valid_o,
  output logic     dmem_write_o,
  output addr_t    dmem_addr_o,
  output word_t    dmem_wdata_o,
  input  logic     dmem_ready_i,
  input  word_t    dmem_rdata_i
);

  typedef enum logic [1:0] {
    X_IDLE,
    X_RUN,
    X_MEM
  } x_state_t;

  x_state_t    state_q;
  addr_t       pc_q;
  instr_kind_t kind_q;
  alu_op_t     alu_op_q;
  word_t       op_a_q;
  word_t       op_b_q;
  word_t       store_data_q;
  word_t       imm_q;
  br_cond_t    cond_q;
  reg_idx_t    rd_q;

  word_t alu_res;
  logic  br_taken;
  logic  take;
  logic  retire;

  // ==========================================================
  // Control
  // ==========================================================
  assign take   = issue.valid && issue.ready;
  assign retire = (state_q == X_RUN) || ((state_q == X_MEM) && dmem_ready_i);

  // Next instruction may enter on the retire edge unless the path turns
  assign issue.ready = (state_q == X_IDLE) || (retire && !redirect_o);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= X_IDLE;
    end else if (take) begin
      if ((issue.kind == KIND_LOAD) || (issue.kind == KIND_STORE)) begin
        state_q <= X_MEM;
      end else begin
        state_q <= X_RUN;
      end
    end else if (retire) begin
      state_q <= X_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pc_q         <= issue.pc;
      kind_q       <= issue.kind;
      alu_op_q     <= issue.alu_op;
      op_a_q       <= issue.op_a;
      op_b_q       <= issue.op_b;
      store_data_q <= issue.store_data;
      imm_q        <= issue.imm;
      cond_q       <= issue.cond;
      rd_q         <= issue.rd;
    end
  end

  // ==========================================================
  // ALU and branch compare
  // ==========================================================
  always_comb begin
    case (alu_op_q)
      ALU_ADD:    alu_res = op_a_q + op_b_q;
      ALU_SUB:    alu_res = op_a_q - op_b_q;
      ALU_SLL:    alu_res = op_a_q << op_b_q[4:0];
      ALU_SLT:    alu_res = word_t'($signed(op_a_q) < $signed(op_b_q));
      ALU_SLTU:   alu_res = word_t'(op_a_q < op_b_q);
      ALU_XOR:    alu_res = op_a_q ^ op_b_q;
      ALU_SRL:    alu_res = op_a_q >> op_b_q[4:0];
      ALU_SRA:    alu_res = $signed(op_a_q) >>> op_b_q[4:0];
      ALU_OR:     alu_res = op_a_q | op_b_q;
      ALU_AND:    alu_res = op_a_q & op_b_q;
      ALU_PASS_B: alu_res = op_b_q;
      default:    alu_res = '0;
    endcase
  end

  // rs2 travels in store_data
  always_comb begin
    case (cond_q)
      `RV_F3_BEQ:  br_taken = (op_a_q == store_data_q);
      `RV_F3_BNE:  br_taken = (op_a_q != store_data_q);
      `RV_F3_BLT:  br_taken = ($signed(op_a_q) < $signed(store_data_q));
      `RV_F3_BGE:  br_taken = ($signed(op_a_q) >= $signed(store_data_q));
      `RV_F3_BLTU: br_taken = (op_a_q < store_data_q);
      `RV_F3_BGEU: br_taken = (op_a_q >= store_data_q);
      default:     br_taken = 1'b0;
    endcase
  end

  assign redirect_o    = (state_q == X_RUN) &&
                         ((kind_q == KIND_JUMP) || ((kind_q == KIND_BRANCH) && br_taken));
  assign redirect_pc_o = pc_q + imm_q;

  // ==========================================================
  // Write-back and data memory
  // ==========================================================

  // Non-writing kinds arrive with rd zero
  assign wr_en_o  = retire && (rd_q != '0);
  assign wr_idx_o = rd_q;

  always_comb begin
    case (kind_q)
      KIND_LOAD: wr_data_o = dmem_rdata_i;
      KIND_JUMP: wr_data_o = pc_q + addr_t'(4);
      default:   wr_data_o = alu_res;
    endcase
  end

  assign busy_o    = (state_q != X_IDLE) && (rd_q != '0);
  assign busy_rd_o = rd_q;

  assign dmem_valid_o = (state_q == X_MEM);
  assign dmem_write_o = (kind_q == KIND_STORE);
  assign dmem_addr_o  = alu_res;
  assign dmem_wdata_o = store_data_q;

  a_dmem_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    dmem_valid_o |-> (dmem_addr_o[1:0] == 2'b00)
  );

endmodule

// File: design/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // Instruction memory
  output logic   imem_valid_o,
  output addr_t  imem_addr_o,
  input  logic   imem_ready_i,
  input  instr_t imem_rdata_i,
  // Data memory
  output logic   dmem_valid_o,
  output logic   dmem_write_o,
  output addr_t  dmem_addr_o,
  output word_t  dmem_wdata_o,
  input  logic   dmem_ready_i,
  input  word_t  dmem_rdata_i
);

  logic     redirect;
  addr_t    redirect_pc;
  logic     busy;
  reg_idx_t busy_rd;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  rv_fetch_if fetch_if ();
  rv_issue_if issue_if ();

  // ==========================================================
  // Pipeline stages
  // ==========================================================
  rv_fetch i_rv_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_valid_o  (imem_valid_o),
    .imem_addr_o   (imem_addr_o),
    .imem_ready_i  (imem_ready_i),
    .imem_rdata_i  (imem_rdata_i),
    .fetch         (fetch_if.producer)
  );

  rv_decode i_rv_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch      (fetch_if.consumer),
    .issue      (issue_if.producer),
    .redirect_i (redirect),
    .busy_i     (busy),
    .busy_rd_i  (busy_rd),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data)
  );

  rv_execute i_rv_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue         (issue_if.consumer),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .busy_o        (busy),
    .busy_rd_o     (busy_rd),
    .wr_en_o       (wr_en),
    .wr_idx_o      (wr_idx),
    .wr_data_o     (wr_data),
    .dmem_valid_o  (dmem_valid_o),
    .dmem_write_o  (dmem_write_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_wdata_o  (dmem_wdata_o),
    .dmem_ready_i  (dmem_ready_i),
    .dmem_rdata_i  (dmem_rdata_i)
  );

endmodule

// File: verif/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int    NUM_TESTS       = 5;
  localparam int    CYCLES_PER_TEST = 2000;
  localparam int    MEM_WORDS       = 256;
  localparam word_t MARKER          = 32'hDEAD_0000;

  // First edge is a falling one so reset lands before any rising edge
  logic   clk          = 1'b1;
  logic   rst_n        = 1'b1;
  logic   imem_valid_o;
  addr_t  imem_addr_o;
  logic   imem_ready_i = 1'b0;
  instr_t imem_rdata_i = '0;
  logic   dmem_valid_o;
  logic   dmem_write_o;
  addr_t  dmem_addr_o;
  word_t  dmem_wdata_o;
  logic   dmem_ready_i = 1'b0;
  word_t  dmem_rdata_i = '0;

  instr_t imem_mem [MEM_WORDS];
  word_t  dmem_mem [MEM_WORDS];
  int     prog_len;
  logic   imem_waits  = 1'b0;
  logic   dmem_waits  = 1'b0;
  int     error_count = 0;

  addr_t log_addr [$];
  word_t log_data [$];
  addr_t exp_addr [$];
  word_t exp_data [$];

  rv_core_top i_rv_core_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_valid_o (imem_valid_o),
    .imem_addr_o  (imem_addr_o),
    .imem_ready_i (imem_ready_i),
    .imem_rdata_i (imem_rdata_i),
    .dmem_valid_o (dmem_valid_o),
    .dmem_write_o (dmem_write_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_ready_i (dmem_ready_i),
    .dmem_rdata_i (dmem_rdata_i)
  );

  always #4 clk = ~clk;

  // ==========================================================
  // Memory models and store monitor
  // ==========================================================
  always @(negedge clk) begin
    imem_ready_i = imem_waits ? ($urandom % 3 != 0) : 1'b1;
    dmem_ready_i = dmem_waits ? ($urandom % 4 == 0) : 1'b1;
    imem_rdata_i = imem_mem[imem_addr_o[9:2]];
    dmem_rdata_i = dmem_mem[dmem_addr_o[9:2]];
  end

  always @(posedge clk) begin
    if (rst_n && dmem_valid_o && dmem_ready_i && dmem_write_o) begin
      dmem_mem[dmem_addr_o[9:2]] = dmem_wdata_o;
      log_addr.push_back(dmem_addr_o);
      log_data.push_back(dmem_wdata_o);
    end
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Errors: %0d", error_count);
    $display("Test failed");
    $finish;
  end

  // ==========================================================
  // Instruction encoders
  // ==========================================================
  function automatic instr_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
  endfunction

  function automatic instr_t enc_i(logic [6:0] op, int imm, int rs1, logic [2:0] f3, int rd);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic instr_t enc_lw(int rd, int off, int rs1);
    return enc_i(`RV_OP_LOAD, off, rs1, `RV_F3_WORD, rd);
  endfunction

  function automatic instr_t enc_s(int off, int rs2, int rs1);
    return {off[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, off[4:0], `RV_OP_STORE};
  endfunction

  function automatic instr_t enc_b(int off, int rs2, int rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic instr_t enc_lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], `RV_OP_LUI};
  endfunction

  function automatic instr_t enc_jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
  endfunction

  // Unwritten data words read back a value tied to their address
  function automatic word_t fill_word(addr_t a);
    return {~a[15:0], a[15:0]} ^ {a[31:16], 16'h0000};
  endfunction

  // ==========================================================
  // Program loading, running and checks
  // ==========================================================
  task automatic check_value(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic emit(instr_t w);
    imem_mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_self_loop();
    emit(enc_b(0, 0, 0, `RV_F3_BEQ));
  endtask

  task automatic expect_store(addr_t a, word_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // Puts the core in reset and clears both memories and the logs
  task automatic start_program();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      // addi x0, x0, index
      imem_mem[i] = enc_i(`RV_OP_IMM, i, 0, `RV_F3_ADD, 0);
      dmem_mem[i] = fill_word(addr_t'(i * 4));
    end
    prog_len = 0;
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic run_and_check(string name);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    while (log_data.size() < exp_data.size()) @(negedge clk);
    // Extra window so a stray late store still shows up
    repeat (50) @(negedge clk);
    check_value({name, " store count"}, exp_data.size(), log_data.size());
    for (int i = 0; i < exp_data.size() && i < log_data.size(); i++) begin
      check_value($sformatf("%s store %0d address", name, i), exp_addr[i], log_addr[i]);
      check_value($sformatf("%s store %0d data", name, i), exp_data[i], log_data[i]);
    end
  endtask

  task automatic build_alu_program();
    word_t a;
    word_t b;
    word_t v [4:24];
    a = 32'h1234_5678;
    b = 32'hFFFF_FFFB;
    emit(enc_lui(1, 20'h12345));
    // Reads x1 right after the LUI that writes it
    emit(enc_i(`RV_OP_IMM, 12'h678, 1, `RV_F3_ADD, 1));
    emit(enc_i(`RV_OP_IMM, -5, 0, `RV_F3_ADD, 2));
    emit(enc_i(`RV_OP_IMM, 3, 0, `RV_F3_ADD, 3));
    emit(enc_r(7'h00, 2, 1, `RV_F3_ADD, 4));
    emit(enc_r(7'h20, 2, 1, `RV_F3_ADD, 5));
    emit(enc_r(7'h00, 2, 1, `RV_F3_AND, 6));
    emit(enc_r(7'h00, 2, 1, `RV_F3_OR, 7));
    emit(enc_r(7'h00, 2, 1, `RV_F3_XOR, 8));
    emit(enc_r(7'h00, 3, 2, `RV_F3_SLT, 9));
    emit(enc_r(7'h00, 3, 2, `RV_F3_SLTU, 10));
    emit(enc_r(7'h00, 3, 1, `RV_F3_SLL, 11));
    emit(enc_r(7'h00, 3, 2, `RV_F3_SR, 12));
    emit(enc_r(7'h20, 3, 2, `RV_F3_SR, 13));
    v[4]  = a + b;
    v[5]  = a - b;
    v[6]  = a & b;
    v[7]  = a | b;
    v[8]  = a ^ b;
    // -5 is below 3 signed, 0xFFFFFFFB is not below 3 unsigned
    v[9]  = 32'd1;
    v[10] = 32'd0;
    v[11] = a << 3;
    v[12] = b >> 3;
    // -5 shifted right arithmetically by 3 is -1
    v[13] = 32'hFFFF_FFFF;
    // Immediate forms
    emit(enc_i(`RV_OP_IMM, -1, 1, `RV_F3_ADD, 14));
    emit(enc_i(`RV_OP_IMM, 12'h0FF, 1, `RV_F3_AND, 15));
    emit(enc_i(`RV_OP_IMM, 12'h100, 2, `RV_F3_OR, 16));
    emit(enc_i(`RV_OP_IMM, -1, 1, `RV_F3_XOR, 17));
    emit(enc_i(`RV_OP_IMM, -4, 2, `RV_F3_SLT, 18));
    emit(enc_i(`RV_OP_IMM, -1, 3, `RV_F3_SLTU, 19));
    emit(enc_i(`RV_OP_IMM, 4, 1, `RV_F3_SLL, 20));
    emit(enc_i(`RV_OP_IMM, 28, 2, `RV_F3_SR, 21));
    emit(enc_i(`RV_OP_IMM, 12'h401, 2, `RV_F3_SR, 22));
    emit(enc_i(`RV_OP_IMM, 7, 22, `RV_F3_ADD, 23));
    emit(enc_r(7'h00, 23, 23, `RV_F3_ADD, 24));
    v[14] = a - 32'd1;
    v[15] = a & 32'h0000_00FF;
    v[16] = b | 32'h0000_0100;
    v[17] = ~a;
    // -5 is below -4, and 3 is below the sign-extended 0xFFFFFFFF
    v[18] = 32'd1;
    v[19] = 32'd1;
    v[20] = a << 4;
    v[21] = b >> 28;
    // -5 shifted right arithmetically by 1 is -3
    v[22] = 32'hFFFF_FFFD;
    v[23] = v[22] + 32'd7;
    v[24] = v[23] + v[23];
    for (int r = 4; r <= 24; r++) begin
      emit(enc_s(12'h100 + 4 * (r - 4), r, 0));
      expect_store(addr_t'(12'h100 + 4 * (r - 4)), v[r]);
    end
    emit_self_loop();
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic test_reset();
    start_program();
    emit_self_loop();
    repeat (3) begin
      @(negedge clk);
      check_value("reset imem_valid", 0, imem_valid_o);
      check_value("reset dmem_valid", 0, dmem_valid_o);
    end
    rst_n = 1'b1;
    // Request expected in the first cycle out of reset
    @(negedge clk);
    check_value("reset first imem_valid", 1, imem_valid_o);
    check_value("reset first address", `RV_RESET_PC, imem_addr_o);
  endtask

  task automatic test_alu();
    start_program();
    build_alu_program();
    run_and_check("alu");
  endtask

  task automatic test_load_store();
    word_t v1;
    word_t v2;
    word_t v3;
    word_t r5;
    v1 = 32'd100;
    v2 = -32'sd200;
    v3 = 32'hABCD_E000;
    r5 = v1 + v1;
    dmem_waits = 1'b1;
    start_program();
    emit(enc_i(`RV_OP_IMM, 100, 0, `RV_F3_ADD, 1));
    emit(enc_i(`RV_OP_IMM, -200, 0, `RV_F3_ADD, 2));
    emit(enc_lui(3, 20'hABCDE));
    emit(enc_s(12'h040, 1, 0));
    emit(enc_s(12'h044, 2, 0));
    emit(enc_s(12'h048, 3, 0));
    // Each load result is used by the next instruction
    emit(enc_lw(4, 12'h040, 0));
    emit(enc_r(7'h00, 4, 4, `RV_F3_ADD, 5));
    emit(enc_lw(6, 12'h044, 0));
    emit(enc_r(7'h20, 5, 6, `RV_F3_ADD, 7));
    emit(enc_lw(8, 12'h048, 0));
    emit(enc_r(7'h00, 1, 8, `RV_F3_ADD, 9));
    emit(enc_lw(10, 12'h300, 0));
    emit(enc_i(`RV_OP_IMM, 1, 10, `RV_F3_ADD, 11));
    emit(enc_i(`RV_OP_IMM, 12'h040, 0, `RV_F3_ADD, 12));
    emit(enc_lw(13, 4, 12));
    emit(enc_s(12'h080, 5, 0));
    emit(enc_s(12'h084, 7, 0));
    emit(enc_s(12'h088, 9, 0));
    emit(enc_s(12'h08C, 11, 0));
    emit(enc_s(12'h090, 13, 0));
    emit_self_loop();
    expect_store(32'h40, v1);
    expect_store(32'h44, v2);
    expect_store(32'h48, v3);
    expect_store(32'h80, r5);
    expect_store(32'h84, v2 - r5);
    expect_store(32'h88, v3 + v1);
    expect_store(32'h8C, fill_word(32'h300) + 32'd1);
    expect_store(32'h90, v2);
    run_and_check("load store");
    dmem_waits = 1'b0;
  endtask

  task automatic test_control_flow();
    logic [2:0] conds [12];
    int         src_a [12];
    int         src_b [12];
    addr_t      jal_pc;
    // x1 is -1 so signed and unsigned compares disagree
    conds = '{`RV_F3_BEQ, `RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BNE, `RV_F3_BLT, `RV_F3_BLT,
              `RV_F3_BGE, `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BLTU, `RV_F3_BGEU, `RV_F3_BGEU};
    src_a = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    src_b = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    start_program();
    emit(enc_i(`RV_OP_IMM, -1, 0, `RV_F3_ADD, 1));
    emit(enc_i(`RV_OP_IMM, 1, 0, `RV_F3_ADD, 2));
    emit(enc_i(`RV_OP_IMM, 1, 0, `RV_F3_ADD, 3));
    emit(enc_i(`RV_OP_IMM, 12'h111, 0, `RV_F3_ADD, 30));
    emit(enc_lui(31, MARKER[31:12]));
    for (int i = 0; i < 12; i++) begin
      emit(enc_b(8, src_b[i], src_a[i], conds[i]));
      // Even cases are taken and jump over a marker store
      if (i % 2 == 0) begin
        emit(enc_s(12'h1F0, 31, 0));
      end
      emit(enc_s(12'h100 + 4 * i, 30, 0));
      expect_store(addr_t'(12'h100 + 4 * i), 32'h111);
    end
    jal_pc = addr_t'(prog_len * 4);
    emit(enc_jal(5, 12));
    emit(enc_s(12'h1F0, 31, 0));
    emit(enc_s(12'h1F0, 31, 0));
    emit(enc_s(12'h180, 5, 0));
    expect_store(32'h180, jal_pc + 32'd4);
    emit_self_loop();
    run_and_check("control");
    foreach (log_data[i]) begin
      if (log_data[i] == MARKER) begin
        error_count++;
        $display("Error: control test stored a skipped-slot marker at address %h",
                 log_addr[i]);
      end
    end
  endtask

  task automatic test_backpressure_x0();
    imem_waits = 1'b1;
    start_program();
    build_alu_program();
    run_and_check("alu stalled");
    // x0 written and then stored at once
    start_program();
    emit(enc_i(`RV_OP_IMM, 77, 0, `RV_F3_ADD, 5));
    emit(enc_r(7'h00, 5, 5, `RV_F3_ADD, 0));
    emit(enc_s(12'h040, 0, 0));
    emit(enc_s(12'h044, 5, 0));
    emit_self_loop();
    expect_store(32'h40, 32'd0);
    expect_store(32'h44, 32'd77);
    run_and_check("x0");
    imem_waits = 1'b0;
  endtask

  initial begin
    void'($urandom(97));
    test_reset();
    test_alu();
    test_load_store();
    test_control_flow();
    test_backpressure_x0();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/rv_pkg.sv
design/rv_stage_if.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core_top.sv
verif/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_stage_if.sv
      - design/rv_fetch.sv
      - design/rv_regfile.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_tb.sv
